// File: Makefile
# Verilator simulation of the PC/XT glue logic

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_pcxt_glue -f sim.f --Mdir obj_dir -o tb_pcxt_glue
	./obj_dir/tb_pcxt_glue | tee sim.log
	grep -qx "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: logic/activity_led.sv
// Retriggerable hold counter stretching disk activity onto the user LED
`timescale 1ns/1ps
`default_nettype none

module activity_led #(
	parameter int hold_cycles = pcxt_glue_pkg::DEF_LED_HOLD
) (
	input  wire  CLK_50M,
	input  wire  reset,
	input  wire  disk_activity,
	output logic led_user
);

	localparam int CNT_W = $clog2(hold_cycles + 1);

	logic [CNT_W-1:0] hold_cnt;

	// Each pulse restarts the full hold time
	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			hold_cnt <= '0;
		end else if (disk_activity) begin
			hold_cnt <= CNT_W'(hold_cycles);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	// Lit for as long as time remains
	assign led_user = (hold_cnt != '0);

	// No pulse gets lost
	a_led_follows_pulse: assert property (
		@(posedge CLK_50M) disable iff (reset)
		disk_activity |=> led_user
	);

endmodule

`default_nettype wire

// File: logic/mono_tint.sv
// Luminance tables and registered colour, green, amber and grey tint stage with MDA bypass
`timescale 1ns/1ps
`default_nettype none

module mono_tint (
	input  wire                        CLK_50M,
	input  wire                        reset,
	input  wire pcxt_glue_pkg::tint_t  tint,
	input  wire                        video_mda,
	input  wire pcxt_glue_pkg::color6_t r,
	input  wire pcxt_glue_pkg::color6_t g,
	input  wire pcxt_glue_pkg::color6_t b,
	input  wire                        de,
	input  wire                        hs,
	input  wire                        vs,
	output pcxt_glue_pkg::color8_t     vga_r,
	output pcxt_glue_pkg::color8_t     vga_g,
	output pcxt_glue_pkg::color8_t     vga_b,
	output logic                       vga_de,
	output logic                       vga_hs,
	output logic                       vga_vs
);

	// Per channel weight ROMs
	pcxt_glue_pkg::color6_t red_lut   [64];
	pcxt_glue_pkg::color6_t green_lut [64];
	pcxt_glue_pkg::color6_t blue_lut  [64];

	// Luminance, max 13 + 45 + 4
	pcxt_glue_pkg::color6_t lum;

	// Tinted and final 6 bit channels
	pcxt_glue_pkg::color6_t tint_r;
	pcxt_glue_pkg::color6_t tint_g;
	pcxt_glue_pkg::color6_t tint_b;
	pcxt_glue_pkg::color6_t out_r;
	pcxt_glue_pkg::color6_t out_g;
	pcxt_glue_pkg::color6_t out_b;

	////////////////////////////////////////////////////////////
	// Weight tables
	////////////////////////////////////////////////////////////

	// Constant contents, folded into ROM by synthesis
	for (genvar i = 0; i < 64; i++) begin : g_lut
		assign red_lut[i]   = pcxt_glue_pkg::lum_weight(6'(i), pcxt_glue_pkg::W_RED);
		assign green_lut[i] = pcxt_glue_pkg::lum_weight(6'(i), pcxt_glue_pkg::W_GREEN);
		assign blue_lut[i]  = pcxt_glue_pkg::lum_weight(6'(i), pcxt_glue_pkg::W_BLUE);
	end

	assign lum = red_lut[r] + green_lut[g] + blue_lut[b];

	////////////////////////////////////////////////////////////
	// Palette select
	////////////////////////////////////////////////////////////

	always_comb begin
		case (tint)
			pcxt_glue_pkg::TINT_GREEN: begin
				tint_r = '0;
				tint_g = lum;
				tint_b = '0;
			end
			pcxt_glue_pkg::TINT_AMBER: begin
				// Half green gives the orange cast
				tint_r = lum;
				tint_g = lum >> 1;
				tint_b = '0;
			end
			pcxt_glue_pkg::TINT_BW: begin
				tint_r = lum;
				tint_g = lum;
				tint_b = lum;
			end
			default: begin
				tint_r = r;
				tint_g = g;
				tint_b = b;
			end
		endcase
	end

	// MDA has its own palette handling upstream
	assign out_r = video_mda ? r : tint_r;
	assign out_g = video_mda ? g : tint_g;
	assign out_b = video_mda ? b : tint_b;

	////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////

	// Syncs ride alongside so pixel and timing stay aligned
	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_de <= 1'b0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			vga_r  <= {out_r, 2'b00};
			vga_g  <= {out_g, 2'b00};
			vga_b  <= {out_b, 2'b00};
			vga_de <= de;
			vga_hs <= hs;
			vga_vs <= vs;
		end
	end

	// Green and amber never carry blue one cycle later
	a_mono_no_blue: assert property (
		@(posedge CLK_50M) disable iff (reset)
		(!$past(video_mda) && ($past(tint) == pcxt_glue_pkg::TINT_GREEN ||
			$past(tint) == pcxt_glue_pkg::TINT_AMBER)) |-> (vga_b == '0)
	);

endmodule

`default_nettype wire

// File: logic/pcxt_glue_pkg.sv
// Shared types, status bit map, DIP switch bytes, luminance weights and default counts
`default_nettype none

package pcxt_glue_pkg;

	////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////

	// OSD status word as delivered by the menu
	typedef logic [31:0] status_t;

	// Video channels, raw 6 bit and widened VGA 8 bit
	typedef logic [5:0] color6_t;
	typedef logic [7:0] color8_t;

	// CGA palette select, status bits 2:1
	typedef enum logic [1:0] {
		TINT_COLOR = 2'd0,
		TINT_GREEN = 2'd1,
		TINT_AMBER = 2'd2,
		TINT_BW    = 2'd3
	} tint_t;

	typedef enum logic {
		SPLASH_SHOW = 1'b0,
		SPLASH_DONE = 1'b1
	} splash_state_t;

	// Audio
	typedef logic signed [15:0] sample_t;
	typedef logic [7:0] tandy_t;

	// HDMI aspect value
	typedef logic [12:0] aspect_t;

	////////////////////////////////////////////////////////////
	// Status word bit map
	////////////////////////////////////////////////////////////

	localparam int ST_CGA_LO      = 1;	// two bits, 2:1
	localparam int ST_SPLASH_SKIP = 3;
	localparam int ST_VIDEO_MDA   = 4;
	localparam int ST_AR_LO       = 8;	// two bits, 9:8

	// DIP switch bytes read back through port C
	localparam logic [7:0] SW_CGA = 8'h2D;
	localparam logic [7:0] SW_MDA = 8'h3D;

	// Luminance coefficients, scaled by 256
	localparam logic [7:0] W_RED   = 8'd54;
	localparam logic [7:0] W_GREEN = 8'd183;
	localparam logic [7:0] W_BLUE  = 8'd18;

	// Splash length and default cycle counts at 50 MHz
	localparam int SPLASH_SECONDS  = 5;
	localparam int DEF_TICK_CYCLES = 50_000_000;
	localparam int DEF_LED_HOLD    = 4_500_000;

	// Rounded channel weight, (v * coef + 128) >> 8
	// Largest product 63 * 255 + 128 still fits in 14 bits
	function automatic color6_t lum_weight(input color6_t v, input logic [7:0] coef);
		logic [13:0] prod;
		prod = 14'(v) * 14'(coef) + 14'd128;
		return color6_t'(prod >> 8);
	endfunction

endpackage

`default_nettype wire

// File: logic/pcxt_glue_top.sv
// Top level wiring status decode into splash, tint, mixer and LED logic
`timescale 1ns/1ps
`default_nettype none

module pcxt_glue_top #(
	parameter int tick_cycles = pcxt_glue_pkg::DEF_TICK_CYCLES,
	parameter int led_hold    = pcxt_glue_pkg::DEF_LED_HOLD
) (
	input  wire                          CLK_50M,
	input  wire                          reset,
	// OSD status
	input  wire                          status_wr,
	input  wire pcxt_glue_pkg::status_t  status_data,
	input  wire                          port_b_sel,
	output pcxt_glue_pkg::aspect_t       video_arx,
	output pcxt_glue_pkg::aspect_t       video_ary,
	output logic [3:0]                   switch_nibble,
	output logic                         splash_active,
	// Video
	input  wire pcxt_glue_pkg::color6_t  r,
	input  wire pcxt_glue_pkg::color6_t  g,
	input  wire pcxt_glue_pkg::color6_t  b,
	input  wire                          de,
	input  wire                          hs,
	input  wire                          vs,
	output pcxt_glue_pkg::color8_t       vga_r,
	output pcxt_glue_pkg::color8_t       vga_g,
	output pcxt_glue_pkg::color8_t       vga_b,
	output logic                         vga_de,
	output logic                         vga_hs,
	output logic                         vga_vs,
	// Audio
	input  wire pcxt_glue_pkg::sample_t  opl_sample,
	input  wire                          speaker,
	input  wire pcxt_glue_pkg::tandy_t   tandy_sample,
	output pcxt_glue_pkg::sample_t       audio_l,
	output pcxt_glue_pkg::sample_t       audio_r,
	// Disk LED
	input  wire                          disk_activity,
	output logic                         led_user
);

	// Decoded menu fields
	pcxt_glue_pkg::tint_t tint;
	logic                 video_mda;
	logic                 splash_skip;

	////////////////////////////////////////////////////////////
	// Configuration
	////////////////////////////////////////////////////////////

	status_regs u_status_regs (
		.CLK_50M       (CLK_50M),
		.reset         (reset),
		.status_wr     (status_wr),
		.status_data   (status_data),
		.port_b_sel    (port_b_sel),
		.tint          (tint),
		.video_mda     (video_mda),
		.splash_skip   (splash_skip),
		.video_arx     (video_arx),
		.video_ary     (video_ary),
		.switch_nibble (switch_nibble)
	);

	// Core reset hold while the logo shows
	splash_timer #(.tick_cycles(tick_cycles)) u_splash_timer (
		.CLK_50M       (CLK_50M),
		.reset         (reset),
		.splash_skip   (splash_skip),
		.splash_active (splash_active)
	);

	////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////

	mono_tint u_mono_tint (
		.CLK_50M   (CLK_50M),
		.reset     (reset),
		.tint      (tint),
		.video_mda (video_mda),
		.r         (r),
		.g         (g),
		.b         (b),
		.de        (de),
		.hs        (hs),
		.vs        (vs),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b),
		.vga_de    (vga_de),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs)
	);

	sound_mixer u_sound_mixer (
		.CLK_50M      (CLK_50M),
		.reset        (reset),
		.opl_sample   (opl_sample),
		.speaker      (speaker),
		.tandy_sample (tandy_sample),
		.audio_l      (audio_l),
		.audio_r      (audio_r)
	);

	// fdd activity stretcher
	activity_led #(.hold_cycles(led_hold)) u_activity_led (
		.CLK_50M       (CLK_50M),
		.reset         (reset),
		.disk_activity (disk_activity),
		.led_user      (led_user)
	);

endmodule

`default_nettype wire

// File: logic/sound_mixer.sv
// Registered signed mix of OPL, speaker and Tandy audio
`timescale 1ns/1ps
`default_nettype none

module sound_mixer (
	input  wire                         CLK_50M,
	input  wire                         reset,
	input  wire pcxt_glue_pkg::sample_t opl_sample,
	input  wire                         speaker,
	input  wire pcxt_glue_pkg::tandy_t  tandy_sample,
	output pcxt_glue_pkg::sample_t      audio_l,
	output pcxt_glue_pkg::sample_t      audio_r
);

	// Scaled terms, 17 bit headroom
	logic [16:0] opl_term;
	logic [16:0] spk_term;
	logic [16:0] tandy_term;
	logic [16:0] mix_sum;

	pcxt_glue_pkg::sample_t audio_q;

	// OPL sign extended then x4
	assign opl_term = {opl_sample[15], opl_sample} << 2;

	// Speaker is a full scale square wave
	assign spk_term = {1'b0, speaker, 15'd0};

	// Tandy level sits at x256
	assign tandy_term = {1'b0, tandy_sample, 8'd0};

	// wraps in 17 bits, no saturation
	assign mix_sum = opl_term + spk_term + tandy_term;

	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			audio_q <= '0;
		end else begin
			// Drop the LSB back to 16 bits
			audio_q <= mix_sum[16:1];
		end
	end

	// Mono, both channels share one register
	assign audio_l = audio_q;
	assign audio_r = audio_q;

endmodule

`default_nettype wire

// File: logic/splash_timer.sv
// Splash screen FSM with cycle and seconds counters holding the core in reset
`timescale 1ns/1ps
`default_nettype none

module splash_timer #(
	parameter int tick_cycles = pcxt_glue_pkg::DEF_TICK_CYCLES
) (
	input  wire  CLK_50M,
	input  wire  reset,
	input  wire  splash_skip,
	output logic splash_active
);

	// Cycle counter wraps once per second
	localparam int CYC_W = (tick_cycles > 1) ? $clog2(tick_cycles) : 1;
	localparam int SEC_W = $clog2(pcxt_glue_pkg::SPLASH_SECONDS + 1);

	pcxt_glue_pkg::splash_state_t state;
	logic [CYC_W-1:0] cyc_cnt;
	logic [SEC_W-1:0] sec_cnt;

	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			state   <= pcxt_glue_pkg::SPLASH_SHOW;
			cyc_cnt <= '0;
			sec_cnt <= '0;
		end else begin
			case (state)
				pcxt_glue_pkg::SPLASH_SHOW: begin
					// Skip wins over the running count
					if (splash_skip) begin
						state <= pcxt_glue_pkg::SPLASH_DONE;
					end else if (sec_cnt == SEC_W'(pcxt_glue_pkg::SPLASH_SECONDS)) begin
						state <= pcxt_glue_pkg::SPLASH_DONE;
					end else if (cyc_cnt == CYC_W'(tick_cycles - 1)) begin
						// One second elapsed
						cyc_cnt <= '0;
						sec_cnt <= sec_cnt + 1'b1;
					end else begin
						cyc_cnt <= cyc_cnt + 1'b1;
					end
				end
				default: begin
					// Sticky until the next reset
					state <= pcxt_glue_pkg::SPLASH_DONE;
				end
			endcase
		end
	end

	assign splash_active = (state == pcxt_glue_pkg::SPLASH_SHOW);

	// Splash only comes back through reset
	a_no_rise_without_reset: assert property (
		@(posedge CLK_50M) disable iff (reset)
		$rose(splash_active) |-> $past(reset)
	);

endmodule

`default_nettype wire

// File: logic/status_regs.sv
// Status word register with palette, video, splash, aspect and DIP switch decode
`timescale 1ns/1ps
`default_nettype none

module status_regs (
	input  wire                     CLK_50M,
	input  wire                     reset,
	input  wire                     status_wr,
	input  wire pcxt_glue_pkg::status_t status_data,
	input  wire                     port_b_sel,
	output pcxt_glue_pkg::tint_t    tint,
	output logic                    video_mda,
	output logic                    splash_skip,
	output pcxt_glue_pkg::aspect_t  video_arx,
	output pcxt_glue_pkg::aspect_t  video_ary,
	output logic [3:0]              switch_nibble
);

	pcxt_glue_pkg::status_t status_q;

	// Aspect field and selected switch byte
	logic [1:0] ar;
	logic [7:0] sw_byte;

	////////////////////////////////////////////////////////////
	// Status word
	////////////////////////////////////////////////////////////

	// Menu writes land whole, no partial update
	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			status_q <= '0;
		end else if (status_wr) begin
			status_q <= status_data;
		end
	end

	////////////////////////////////////////////////////////////
	// Field decode
	////////////////////////////////////////////////////////////

	// Palette select for the CGA path
	assign tint = pcxt_glue_pkg::tint_t'(status_q[pcxt_glue_pkg::ST_CGA_LO +: 2]);

	// MDA card instead of Tandy/CGA
	assign video_mda = status_q[pcxt_glue_pkg::ST_VIDEO_MDA];

	// Menu option "splash screen: no"
	assign splash_skip = status_q[pcxt_glue_pkg::ST_SPLASH_SKIP];

	assign ar = status_q[pcxt_glue_pkg::ST_AR_LO +: 2];

	// Original 4:3, otherwise scaler preset index ar-1 with ary zero
	always_comb begin
		if (ar == 2'd0) begin
			video_arx = 13'd4;
			video_ary = 13'd3;
		end else begin
			video_arx = {11'd0, ar} - 13'd1;
			video_ary = 13'd0;
		end
	end

	// DIP switches follow the fitted video card
	assign sw_byte = video_mda ? pcxt_glue_pkg::SW_MDA : pcxt_glue_pkg::SW_CGA;

	// Port B bit 3 picks the high or low switch bank
	assign switch_nibble = port_b_sel ? sw_byte[7:4] : sw_byte[3:0];

endmodule

`default_nettype wire

// File: sim.f
logic/pcxt_glue_pkg.sv
logic/status_regs.sv
logic/splash_timer.sv
logic/mono_tint.sv
logic/sound_mixer.sv
logic/activity_led.sv
logic/pcxt_glue_top.sv
verif/tb_pcxt_glue.sv

// File: verif/tb_pcxt_glue.sv
// Random-stimulus testbench with reference models for splash, status decode, tint, mixer and LED
`timescale 1ns/1ps
`default_nettype none

module tb_pcxt_glue;

	// Shortened counts for simulation
	localparam int TICK     = 20;
	localparam int HOLD     = 12;
	localparam int SECS     = pcxt_glue_pkg::SPLASH_SECONDS;
	localparam int STATUS_N = 200;
	localparam int PIXEL_N  = 300;
	localparam int MIX_N    = 400;
	localparam int LED_N    = 600;

	// Cycle budget per test, summed for the watchdog
	localparam int SPLASH_LEN  = 2 * (SECS * TICK + SECS + 60);
	localparam int STATUS_LEN  = 4 * STATUS_N;
	localparam int TINT_LEN    = 5 * (PIXEL_N + 4);
	localparam int MIX_LEN     = MIX_N + 4;
	localparam int LED_LEN     = LED_N + 4;
	localparam int TIMEOUT_CYC = SPLASH_LEN + STATUS_LEN + TINT_LEN + MIX_LEN + LED_LEN + 500;

	logic        CLK_50M;
	logic        reset;
	logic        status_wr;
	logic [31:0] status_data;
	logic        port_b_sel;
	logic [12:0] video_arx;
	logic [12:0] video_ary;
	logic [3:0]  switch_nibble;
	logic        splash_active;
	logic [5:0]  r;
	logic [5:0]  g;
	logic [5:0]  b;
	logic        de;
	logic        hs;
	logic        vs;
	logic [7:0]  vga_r;
	logic [7:0]  vga_g;
	logic [7:0]  vga_b;
	logic        vga_de;
	logic        vga_hs;
	logic        vga_vs;
	logic [15:0] opl_sample;
	logic        speaker;
	logic [7:0]  tandy_sample;
	logic [15:0] audio_l;
	logic [15:0] audio_r;
	logic        disk_activity;
	logic        led_user;

	// LCG state and score
	logic [31:0] seed;
	int          errors;
	int          checks;
	int          tests;
	int          test_errors;
	int          test_checks;

	pcxt_glue_top #(
		.tick_cycles (TICK),
		.led_hold    (HOLD)
	) u_dut (
		.CLK_50M       (CLK_50M),
		.reset         (reset),
		.status_wr     (status_wr),
		.status_data   (status_data),
		.port_b_sel    (port_b_sel),
		.video_arx     (video_arx),
		.video_ary     (video_ary),
		.switch_nibble (switch_nibble),
		.splash_active (splash_active),
		.r             (r),
		.g             (g),
		.b             (b),
		.de            (de),
		.hs            (hs),
		.vs            (vs),
		.vga_r         (vga_r),
		.vga_g         (vga_g),
		.vga_b         (vga_b),
		.vga_de        (vga_de),
		.vga_hs        (vga_hs),
		.vga_vs        (vga_vs),
		.opl_sample    (opl_sample),
		.speaker       (speaker),
		.tandy_sample  (tandy_sample),
		.audio_l       (audio_l),
		.audio_r       (audio_r),
		.disk_activity (disk_activity),
		.led_user      (led_user)
	);

	// 50 MHz
	initial begin
		CLK_50M = 1'b0;
		forever #10 CLK_50M = ~CLK_50M;
	end

	////////////////////////////////////////////////////////////
	// Random source, models, check helpers
	////////////////////////////////////////////////////////////

	// Upper half of the LCG state, low bits are too regular
	function automatic logic [15:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[31:16];
	endfunction

	// Rounded luminance share of one channel
	function automatic int channel_weight(input int v, input int coef);
		return (v * coef + 128) / 256;
	endfunction

	// Expected {vga_r, vga_g, vga_b, de, hs, vs}
	function automatic logic [26:0] tint_model(input logic [1:0] pal, input logic mda,
			input logic [5:0] ri, input logic [5:0] gi, input logic [5:0] bi,
			input logic [2:0] syncs);
		int         lum;
		logic [5:0] l6;
		logic [5:0] ro;
		logic [5:0] go;
		logic [5:0] bo;
		lum = channel_weight(int'(ri), int'(pcxt_glue_pkg::W_RED))
			+ channel_weight(int'(gi), int'(pcxt_glue_pkg::W_GREEN))
			+ channel_weight(int'(bi), int'(pcxt_glue_pkg::W_BLUE));
		l6 = lum[5:0];
		ro = ri;
		go = gi;
		bo = bi;
		// MDA keeps its own colours
		if (!mda) begin
			case (pal)
				2'd1: begin
					ro = 6'd0;
					go = l6;
					bo = 6'd0;
				end
				2'd2: begin
					ro = l6;
					go = l6 >> 1;
					bo = 6'd0;
				end
				2'd3: begin
					ro = l6;
					go = l6;
					bo = l6;
				end
				default: ;
			endcase
		end
		return {ro, 2'b00, go, 2'b00, bo, 2'b00, syncs};
	endfunction

	// Signed sum wrapped to 17 bits, top 16 kept
	function automatic logic [15:0] mix_model(input logic [15:0] opl, input logic spk,
			input logic [7:0] tdy);
		int          sum;
		logic [16:0] wrapped;
		sum = int'($signed(opl)) * 4 + (spk ? 32768 : 0) + int'(tdy) * 256;
		wrapped = sum[16:0];
		return wrapped[16:1];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		test_checks++;
		assert (got === exp) else begin
			$display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_true(input logic ok, input string what);
		checks++;
		test_checks++;
		assert (ok) else begin
			$display("Error: %s at %0t", what, $time);
			errors++;
			test_errors++;
		end
	endtask

	task automatic start_test();
		test_errors = 0;
		test_checks = 0;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("Test %s done: %0d checks, %0d errors", name, test_checks, test_errors);
	endtask

	task automatic apply_reset();
		@(posedge CLK_50M);
		reset <= 1'b1;
		repeat (5) @(posedge CLK_50M);
		reset <= 1'b0;
	endtask

	task automatic compare_pixel(input logic [26:0] exp);
		check_value("vga_r", 32'(vga_r), 32'(exp[26:19]));
		check_value("vga_g", 32'(vga_g), 32'(exp[18:11]));
		check_value("vga_b", 32'(vga_b), 32'(exp[10:3]));
		check_value("vga_de", 32'(vga_de), 32'(exp[2]));
		check_value("vga_hs", 32'(vga_hs), 32'(exp[1]));
		check_value("vga_vs", 32'(vga_vs), 32'(exp[0]));
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	// Entered on the edge that releases reset
	task automatic run_splash();
		int   n;
		logic fell;
		start_test();
		n = 0;
		fell = 1'b0;
		// n counts clock edges since release, sampled mid cycle
		while (!fell && n < 2 * SECS * TICK) begin
			@(posedge CLK_50M);
			n++;
			@(negedge CLK_50M);
			fell = !splash_active;
		end
		check_true(fell, "splash_active never fell with skip clear");
		check_true(n >= SECS * TICK && n <= SECS * TICK + SECS + 2,
			$sformatf("splash_active fell after %0d cycles, outside its window", n));
		repeat (40) begin
			@(negedge CLK_50M);
			check_true(!splash_active, "splash_active rose again without reset");
		end
		// Second pass, skip bit written right after reset
		apply_reset();
		@(negedge CLK_50M);
		check_true(splash_active, "splash_active low after reset");
		@(posedge CLK_50M);
		status_wr <= 1'b1;
		status_data <= 32'(1) << pcxt_glue_pkg::ST_SPLASH_SKIP;
		n = 0;
		fell = 1'b0;
		// Edges counted from the one that drives the write
		while (!fell && n < 10) begin
			@(posedge CLK_50M);
			n++;
			@(negedge CLK_50M);
			fell = !splash_active;
		end
		check_true(fell && n <= 2, $sformatf("splash skip took %0d cycles", n));
		@(posedge CLK_50M);
		status_wr <= 1'b0;
		repeat (10) begin
			@(negedge CLK_50M);
			check_true(!splash_active, "splash_active rose again after skip");
		end
		end_test("splash");
	endtask

	task automatic run_status();
		logic [31:0] word;
		logic [15:0] rnd;
		logic        sel;
		logic [1:0]  ar;
		logic [7:0]  sw;
		start_test();
		repeat (STATUS_N) begin
			word = {next_rand(), next_rand()};
			rnd = next_rand();
			sel = rnd[9];
			@(posedge CLK_50M);
			status_wr <= 1'b1;
			status_data <= word;
			port_b_sel <= sel;
			@(posedge CLK_50M);
			status_wr <= 1'b0;
			@(negedge CLK_50M);
			ar = word[pcxt_glue_pkg::ST_AR_LO +: 2];
			sw = word[pcxt_glue_pkg::ST_VIDEO_MDA] ? pcxt_glue_pkg::SW_MDA : pcxt_glue_pkg::SW_CGA;
			// 4:3 default, otherwise scaler preset
			check_value("video_arx", 32'(video_arx), (ar == 2'd0) ? 32'd4 : 32'(ar) - 32'd1);
			check_value("video_ary", 32'(video_ary), (ar == 2'd0) ? 32'd3 : 32'd0);
			check_value("switch_nibble", 32'(switch_nibble), 32'(sel ? sw[7:4] : sw[3:0]));
			// Other bank, same word
			@(posedge CLK_50M);
			port_b_sel <= !sel;
			@(negedge CLK_50M);
			check_value("switch_nibble", 32'(switch_nibble), 32'(sel ? sw[3:0] : sw[7:4]));
		end
		end_test("status");
	endtask

	// One palette pass, one pixel per cycle in flight
	task automatic run_tint(input logic [1:0] pal, input logic mda);
		logic [15:0] rnd_a;
		logic [15:0] rnd_b;
		logic [26:0] exp_prev;
		logic [26:0] exp_next;
		@(posedge CLK_50M);
		status_wr <= 1'b1;
		status_data <= {27'd0, mda, 1'b0, pal, 1'b0};
		@(posedge CLK_50M);
		status_wr <= 1'b0;
		exp_prev = '0;
		for (int i = 0; i < PIXEL_N; i++) begin
			rnd_a = next_rand();
			rnd_b = next_rand();
			r <= rnd_a[15:10];
			g <= rnd_a[9:4];
			b <= rnd_b[15:10];
			de <= rnd_b[3];
			hs <= rnd_b[5];
			vs <= rnd_b[7];
			exp_next = tint_model(pal, mda, rnd_a[15:10], rnd_a[9:4], rnd_b[15:10],
				{rnd_b[3], rnd_b[5], rnd_b[7]});
			@(negedge CLK_50M);
			// Output now shows the previous pixel
			if (i > 0) begin
				compare_pixel(exp_prev);
			end
			exp_prev = exp_next;
			@(posedge CLK_50M);
		end
		@(negedge CLK_50M);
		compare_pixel(exp_prev);
	endtask

	task automatic run_mixer();
		logic [15:0] rnd;
		logic [15:0] opl;
		logic        spk;
		logic [7:0]  tdy;
		logic [15:0] exp_prev;
		logic [15:0] exp_next;
		start_test();
		exp_prev = '0;
		@(posedge CLK_50M);
		for (int i = 0; i < MIX_N; i++) begin
			rnd = next_rand();
			opl = next_rand();
			spk = rnd[11];
			tdy = rnd[15:8];
			// Corner cases first, all extreme combinations
			if (i < 8) begin
				opl = i[0] ? 16'h8000 : 16'h7FFF;
				spk = i[1];
				tdy = i[2] ? 8'hFF : 8'h00;
			end
			opl_sample <= opl;
			speaker <= spk;
			tandy_sample <= tdy;
			exp_next = mix_model(opl, spk, tdy);
			@(negedge CLK_50M);
			if (i > 0) begin
				check_value("audio_l", 32'(audio_l), 32'(exp_prev));
				check_value("audio_r", 32'(audio_r), 32'(exp_prev));
			end
			exp_prev = exp_next;
			@(posedge CLK_50M);
		end
		@(negedge CLK_50M);
		check_value("audio_l", 32'(audio_l), 32'(exp_prev));
		check_value("audio_r", 32'(audio_r), 32'(exp_prev));
		end_test("mixer");
	endtask

	task automatic run_led();
		int          model_cnt;
		logic        act_prev;
		logic        act;
		logic [15:0] rnd;
		start_test();
		// No pulse since reset, counter idle
		model_cnt = 0;
		act_prev = 1'b0;
		for (int i = 0; i < LED_N; i++) begin
			@(posedge CLK_50M);
			// Follow the edge the DUT just took
			if (act_prev) begin
				model_cnt = HOLD;
			end else if (model_cnt > 0) begin
				model_cnt--;
			end
			rnd = next_rand();
			// Sparse pulses, quiet tail for the last expiry
			act = (rnd[15:12] == 4'd0) && (i < LED_N - 3 * HOLD);
			disk_activity <= act;
			act_prev = act;
			@(negedge CLK_50M);
			check_value("led_user", 32'(led_user), 32'(model_cnt != 0));
		end
		end_test("led");
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////

	initial begin
		logic [15:0] rnd;
		seed = 32'hb6f9;
		errors = 0;
		checks = 0;
		tests = 0;
		test_errors = 0;
		test_checks = 0;
		reset = 1'b1;
		status_wr = 1'b0;
		status_data = '0;
		port_b_sel = 1'b0;
		r = '0;
		g = '0;
		b = '0;
		de = 1'b0;
		hs = 1'b0;
		vs = 1'b0;
		opl_sample = '0;
		speaker = 1'b0;
		tandy_sample = '0;
		disk_activity = 1'b0;
		repeat (5) @(posedge CLK_50M);
		reset <= 1'b0;
		run_splash();
		run_status();
		start_test();
		// Colour, green, amber, grey, then MDA under a random palette
		for (int p = 0; p < 4; p++) begin
			run_tint(2'(p), 1'b0);
		end
		rnd = next_rand();
		run_tint(rnd[14:13], 1'b1);
		end_test("tint");
		run_mixer();
		run_led();
		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	initial begin
		repeat (TIMEOUT_CYC) @(posedge CLK_50M);
		$display("Timeout: tests did not complete within %0d cycles", TIMEOUT_CYC);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire
